/* bench/programTable.svh */
// program words in address order, each with its address in the comment
// expected stores are word address and data, in the order the core makes them

task automatic buildTables();
	// alu chain, every result feeds the next
	pushWord(immWord(cpuPkg::opAddi, 1, 0, -7)); // 0  r1 = -7
	pushWord(aluWord(cpuPkg::aluAdd, 2, 1, 1, 0)); // 1  r2 = -14
	pushWord(aluWord(cpuPkg::aluSub, 3, 1, 2, 0)); // 2  r3 = 7
	pushWord(aluWord(cpuPkg::aluAnd, 4, 3, 2, 0)); // 3  r4 = 2
	pushWord(aluWord(cpuPkg::aluOr, 5, 4, 1, 0)); // 4  r5 = -5
	pushWord(aluWord(cpuPkg::aluSll, 6, 5, 0, 4)); // 5  r6 = -80
	pushWord(aluWord(cpuPkg::aluSra, 7, 6, 0, 3)); // 6  r7 = -10
	pushWord(immWord(cpuPkg::opSw, 1, 0, 1)); // 7
	pushWord(immWord(cpuPkg::opSw, 2, 0, 2)); // 8
	pushWord(immWord(cpuPkg::opSw, 3, 0, 3)); // 9
	pushWord(immWord(cpuPkg::opSw, 4, 0, 4)); // 10
	pushWord(immWord(cpuPkg::opSw, 5, 0, 5)); // 11
	pushWord(immWord(cpuPkg::opSw, 6, 0, 6)); // 12
	pushWord(immWord(cpuPkg::opSw, 7, 0, 7)); // 13
	// load-use stall, then load straight into store data
	pushWord(immWord(cpuPkg::opSw, 3, 0, 8)); // 14
	pushWord(immWord(cpuPkg::opLw, 8, 0, 8)); // 15 r8 = 7
	pushWord(aluWord(cpuPkg::aluAdd, 9, 8, 3, 0)); // 16 stalls, r9 = 14
	pushWord(immWord(cpuPkg::opSw, 9, 0, 9)); // 17
	pushWord(immWord(cpuPkg::opLw, 10, 0, 9)); // 18
	pushWord(immWord(cpuPkg::opSw, 10, 0, 10)); // 19 WM bypass
	// branches, shadow stores go to ee and ef
	pushWord(immWord(cpuPkg::opBne, 1, 2, 2)); // 20 taken to 23
	pushWord(immWord(cpuPkg::opSw, 4, 0, 'hee)); // 21
	pushWord(immWord(cpuPkg::opSw, 4, 0, 'hef)); // 22
	pushWord(immWord(cpuPkg::opSw, 1, 0, 11)); // 23
	pushWord(immWord(cpuPkg::opBne, 1, 1, 2)); // 24 not taken
	pushWord(immWord(cpuPkg::opSw, 2, 0, 12)); // 25
	pushWord(immWord(cpuPkg::opSw, 3, 0, 13)); // 26
	pushWord(immWord(cpuPkg::opBlt, 2, 1, 2)); // 27 -14 < -7, taken to 30
	pushWord(immWord(cpuPkg::opSw, 4, 0, 'hee)); // 28
	pushWord(immWord(cpuPkg::opSw, 4, 0, 'hef)); // 29
	pushWord(immWord(cpuPkg::opSw, 4, 0, 14)); // 30
	pushWord(immWord(cpuPkg::opBlt, 1, 2, 2)); // 31 not taken
	pushWord(immWord(cpuPkg::opSw, 5, 0, 15)); // 32
	pushWord(immWord(cpuPkg::opSw, 6, 0, 16)); // 33
	// call and return, then a write to r0
	pushWord(jumpWord(cpuPkg::opJal, 40)); // 34 r31 = 35
	pushWord(immWord(cpuPkg::opSw, 7, 0, 18)); // 35 return lands here
	pushWord(immWord(cpuPkg::opAddi, 0, 0, 99)); // 36
	pushWord(immWord(cpuPkg::opSw, 0, 0, 19)); // 37
	pushWord(jumpWord(cpuPkg::opJ, 38)); // 38 halt loop
	pushWord('0); // 39
	pushWord(immWord(cpuPkg::opSw, 31, 0, 17)); // 40 subroutine
	pushWord(immWord(cpuPkg::opJr, 31, 0, 0)); // 41
	pushWord(immWord(cpuPkg::opSw, 4, 0, 'hee)); // 42
	pushWord(immWord(cpuPkg::opSw, 4, 0, 'hef)); // 43

	expectStore(1, 32'hffff_fff9);
	expectStore(2, 32'hffff_fff2);
	expectStore(3, 32'h0000_0007);
	expectStore(4, 32'h0000_0002);
	expectStore(5, 32'hffff_fffb);
	expectStore(6, 32'hffff_ffb0);
	expectStore(7, 32'hffff_fff6);
	expectStore(8, 32'h0000_0007);
	expectStore(9, 32'h0000_000e);
	expectStore(10, 32'h0000_000e);
	expectStore(11, 32'hffff_fff9);
	expectStore(12, 32'hffff_fff2);
	expectStore(13, 32'h0000_0007);
	expectStore(14, 32'h0000_0002);
	expectStore(15, 32'hffff_fffb);
	expectStore(16, 32'hffff_ffb0);
	expectStore(17, 32'h0000_0023); // jal address plus one
	expectStore(18, 32'hffff_fff6);
	expectStore(19, 32'h0000_0000);
endtask

/* bench/cpuBench.sv */
`timescale 1ns/10ps

module cpuBench;

	localparam int progAddrWidth = 12;
	localparam int dataAddrWidth = 12;
	localparam int resetCycles = 16;

	logic clock;
	logic arstN;
	logic progWrite;
	logic [progAddrWidth-1:0] progAddr;
	logic [cpuPkg::dataWidth-1:0] progData;
	logic storeValid;
	logic [dataAddrWidth-1:0] storeAddr;
	logic [cpuPkg::dataWidth-1:0] storeData;

	logic [cpuPkg::dataWidth-1:0] progWords [$];
	logic [dataAddrWidth-1:0] expAddr [$];
	logic [cpuPkg::dataWidth-1:0] expData [$];
	int storesSeen = 0;
	int cycleCount = 0;
	int cycleLimit = 0;
	logic checking = 1'b0; // monitor armed once reset is released

	cpuTop #(.progAddrWidth(progAddrWidth), .dataAddrWidth(dataAddrWidth)) DUT (
		.clock(clock),
		.arstN(arstN),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.storeValid(storeValid),
		.storeAddr(storeAddr),
		.storeData(storeData)
	);

	////////////////////////////////////////////////////////////////////////////
	// instruction encoding, opcode in 31..27 then rd, rs, rt
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [cpuPkg::dataWidth-1:0] aluWord(input cpuPkg::aluOpT op,
			input int rd, input int rs, input int rt, input int shamt);
		return {cpuPkg::opAlu, 5'(rd), 5'(rs), 5'(rt), 5'(shamt), op, 2'b00};
	endfunction

	// 17-bit signed immediate in the low bits
	function automatic logic [cpuPkg::dataWidth-1:0] immWord(input cpuPkg::opcodeT op,
			input int rd, input int rs, input int imm);
		return {op, 5'(rd), 5'(rs), 17'(imm)};
	endfunction

	function automatic logic [cpuPkg::dataWidth-1:0] jumpWord(input cpuPkg::opcodeT op,
			input int target);
		return {op, 27'(target)};
	endfunction

	function automatic void pushWord(input logic [cpuPkg::dataWidth-1:0] word);
		progWords.push_back(word);
	endfunction

	function automatic void expectStore(input int addr, input logic [cpuPkg::dataWidth-1:0] data);
		expAddr.push_back(dataAddrWidth'(addr));
		expData.push_back(data);
	endfunction

	`include "programTable.svh"

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic checkAddr(input logic [dataAddrWidth-1:0] actual,
			input logic [dataAddrWidth-1:0] expected);
		if (actual !== expected)
			stopWithFailure($sformatf("CHECK FAILED storeAddr: got %h, expected %h",
				actual, expected));
	endtask

	task automatic checkData(input logic [cpuPkg::dataWidth-1:0] actual,
			input logic [cpuPkg::dataWidth-1:0] expected);
		if (actual !== expected)
			stopWithFailure($sformatf("CHECK FAILED storeData: got %h, expected %h",
				actual, expected));
	endtask

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// store monitor, sampled mid-cycle
	always @(negedge clock) begin
		if (checking) begin
			cycleCount++;
			if (storeValid) begin
				if (storesSeen >= expAddr.size()) begin
					stopWithFailure($sformatf("unexpected extra store to %h with data %h",
						storeAddr, storeData));
				end else begin
					checkAddr(storeAddr, expAddr[storesSeen]);
					checkData(storeData, expData[storesSeen]);
					storesSeen++;
				end
			end
		end
	end

	initial begin
		arstN = 1'b1;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		buildTables();
		cycleLimit = 4 * progWords.size() + 64;
		#1 arstN = 1'b0; // falling edge starts the async reset

		// one word per cycle, reset held low throughout
		foreach (progWords[i]) begin
			@(posedge clock);
			#1;
			progWrite = 1'b1;
			progAddr = progAddrWidth'(i);
			progData = progWords[i];
		end
		@(posedge clock);
		#1 progWrite = 1'b0;
		repeat (resetCycles) @(posedge clock);
		#1;
		arstN = 1'b1;
		checking = 1'b1;

		while (storesSeen < expAddr.size() && cycleCount < cycleLimit)
			@(posedge clock);
		if (storesSeen == expAddr.size()) begin
			$display("All tests passed");
			$finish;
		end else begin
			stopWithFailure($sformatf("timeout after %0d cycles, only %0d of %0d stores seen",
				cycleCount, storesSeen, expAddr.size()));
		end
	end

endmodule

/* hdl/aluUnit.sv */
`timescale 1ns/10ps

module aluUnit (
	input logic [cpuPkg::dataWidth-1:0] opA,
	input logic [cpuPkg::dataWidth-1:0] opB,
	input cpuPkg::aluOpT aluOp,
	input logic [4:0] shiftAmt,
	output logic [cpuPkg::dataWidth-1:0] result,
	output logic notEqual,
	output logic lessThan
);

	always_comb begin
		case (aluOp)
			cpuPkg::aluAdd: result = opA + opB;
			cpuPkg::aluSub: result = opA - opB;
			cpuPkg::aluAnd: result = opA & opB;
			cpuPkg::aluOr: result = opA | opB;
			cpuPkg::aluSll: result = opA << shiftAmt;
			cpuPkg::aluSra: result = $signed(opA) >>> shiftAmt; // keeps the sign bit
			default: result = '0;
		endcase
	end

	// branch flags, rd against rs
	assign notEqual = (opA != opB);
	assign lessThan = ($signed(opA) < $signed(opB));

endmodule

/* hdl/cpuPkg.sv */
package cpuPkg;

	////////////////////////////////////////////////////////////////////////////
	// widths and fixed registers
	////////////////////////////////////////////////////////////////////////////

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam logic [regAddrWidth-1:0] regLink = 5'd31; // jal return address

	////////////////////////////////////////////////////////////////////////////
	// instruction encodings
	////////////////////////////////////////////////////////////////////////////

	// major opcode, bits 31..27
	typedef enum logic [4:0] {
		opAlu = 5'd0,
		opJ = 5'd1,
		opBne = 5'd2,
		opJal = 5'd3,
		opJr = 5'd4,
		opAddi = 5'd5,
		opBlt = 5'd6,
		opSw = 5'd7,
		opLw = 5'd8
	} opcodeT;

	// alu field of R-type words, bits 6..2
	typedef enum logic [4:0] {
		aluAdd = 5'd0,
		aluSub = 5'd1,
		aluAnd = 5'd2,
		aluOr = 5'd3,
		aluSll = 5'd4,
		aluSra = 5'd5
	} aluOpT;

	// where an execute operand comes from
	typedef enum logic [1:0] {
		bypNone,
		bypMem,
		bypWb
	} bypassSelT;

	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbLink // pc+1 for jal
	} wbSelT;

endpackage

/* hdl/cpuTop.sv */
`timescale 1ns/10ps

module cpuTop #(
	parameter int progAddrWidth = 12,
	parameter int dataAddrWidth = 12
) (
	input logic clock,
	input logic arstN,
	input logic progWrite,
	input logic [progAddrWidth-1:0] progAddr,
	input logic [cpuPkg::dataWidth-1:0] progData,
	output logic storeValid,
	output logic [dataAddrWidth-1:0] storeAddr,
	output logic [cpuPkg::dataWidth-1:0] storeData
);

	logic [cpuPkg::dataWidth-1:0] fetchInstr, decInstr, dataA, dataB;
	logic [cpuPkg::dataWidth-1:0] memReadData, memAddr, wbData;
	logic [progAddrWidth-1:0] pc;
	logic decRegWrite, decMemRead, decMemWrite, decUseImm, decUsesB;
	logic decIsBne, decIsBlt, decIsJump, decIsJr;
	cpuPkg::wbSelT decWbSel;
	cpuPkg::aluOpT decAluOp;
	logic [cpuPkg::regAddrWidth-1:0] readRegA, readRegB, exeRegA, exeRegB;
	logic [cpuPkg::regAddrWidth-1:0] exeRegDst, memRegDst, memStoreReg, wbReg;
	logic exeMemRead, exeValid, memRegWrite, wbEnable, takeTransfer;
	logic stall, flush;
	cpuPkg::bypassSelT bypassA, bypassB, bypassStore;

	assign storeAddr = memAddr[dataAddrWidth-1:0]; // word address into data memory

	progMem #(.progAddrWidth(progAddrWidth)) instrMem (
		.clock(clock), .arstN(arstN), .progWrite(progWrite),
		.progAddr(progAddr), .progData(progData),
		.pc(pc), .instr(fetchInstr)
	);

	dataMem #(.dataAddrWidth(dataAddrWidth)) dataStore (
		.clock(clock), .writeEnable(storeValid), .addr(storeAddr),
		.writeData(storeData), .readData(memReadData)
	);

	instrDecode decoder (
		.instr(decInstr), .regWrite(decRegWrite), .memRead(decMemRead),
		.memWrite(decMemWrite), .useImm(decUseImm), .wbSel(decWbSel), .aluOp(decAluOp),
		.isBne(decIsBne), .isBlt(decIsBlt), .isJump(decIsJump), .isJr(decIsJr),
		.readRegA(readRegA), .readRegB(readRegB)
	);

	regFile registers (
		.clock(clock), .arstN(arstN), .writeEnable(wbEnable), .writeReg(wbReg),
		.writeData(wbData), .readRegA(readRegA), .readRegB(readRegB),
		.dataA(dataA), .dataB(dataB)
	);

	hazardControl hazards (
		.clock(clock), .arstN(arstN), .decRegA(readRegA), .decRegB(readRegB),
		.decUsesB(decUsesB), .exeRegDst(exeRegDst), .exeMemRead(exeMemRead),
		.exeValid(exeValid), .memRegDst(memRegDst), .memRegWrite(memRegWrite),
		.wbRegDst(wbReg), .wbRegWrite(wbEnable), .exeRegA(exeRegA), .exeRegB(exeRegB),
		.memStoreReg(memStoreReg), .takeTransfer(takeTransfer), .stall(stall),
		.flush(flush), .bypassA(bypassA), .bypassB(bypassB), .bypassStore(bypassStore)
	);

	pipeDatapath #(.progAddrWidth(progAddrWidth)) datapath (
		.clock(clock), .arstN(arstN), .fetchInstr(fetchInstr), .pc(pc),
		.decInstr(decInstr), .decRegWrite(decRegWrite), .decMemRead(decMemRead),
		.decMemWrite(decMemWrite), .decUseImm(decUseImm), .decWbSel(decWbSel),
		.decAluOp(decAluOp), .decIsBne(decIsBne), .decIsBlt(decIsBlt),
		.decIsJump(decIsJump), .decIsJr(decIsJr), .decRegA(readRegA), .decRegB(readRegB),
		.dataA(dataA), .dataB(dataB), .stall(stall), .flush(flush),
		.bypassA(bypassA), .bypassB(bypassB), .bypassStore(bypassStore),
		.memReadData(memReadData), .decUsesB(decUsesB), .exeRegDst(exeRegDst),
		.exeMemRead(exeMemRead), .exeValid(exeValid), .exeRegA(exeRegA), .exeRegB(exeRegB),
		.memRegDst(memRegDst), .memRegWrite(memRegWrite), .memStoreReg(memStoreReg),
		.takeTransfer(takeTransfer), .wbEnable(wbEnable), .wbReg(wbReg), .wbData(wbData),
		.memAddr(memAddr), .memWriteData(storeData), .memWrite(storeValid)
	);

endmodule

/* hdl/dataMem.sv */
`timescale 1ns/10ps

module dataMem #(
	parameter int dataAddrWidth = 12
) (
	input logic clock,
	input logic writeEnable,
	input logic [dataAddrWidth-1:0] addr,
	input logic [cpuPkg::dataWidth-1:0] writeData,
	output logic [cpuPkg::dataWidth-1:0] readData
);

	logic [cpuPkg::dataWidth-1:0] words [2**dataAddrWidth];

	always_ff @(posedge clock) begin
		if (writeEnable)
			words[addr] <= writeData;
	end

	assign readData = words[addr]; // same-cycle load data

	assert property (@(posedge clock) writeEnable |-> !$isunknown(addr));

endmodule

/* hdl/hazardControl.sv */
`timescale 1ns/10ps

module hazardControl (
	input logic clock,
	input logic arstN,
	input logic [cpuPkg::regAddrWidth-1:0] decRegA,
	input logic [cpuPkg::regAddrWidth-1:0] decRegB,
	input logic decUsesB,
	input logic [cpuPkg::regAddrWidth-1:0] exeRegDst,
	input logic exeMemRead,
	input logic exeValid,
	input logic [cpuPkg::regAddrWidth-1:0] memRegDst,
	input logic memRegWrite,
	input logic [cpuPkg::regAddrWidth-1:0] wbRegDst,
	input logic wbRegWrite,
	input logic [cpuPkg::regAddrWidth-1:0] exeRegA,
	input logic [cpuPkg::regAddrWidth-1:0] exeRegB,
	input logic [cpuPkg::regAddrWidth-1:0] memStoreReg,
	input logic takeTransfer,
	output logic stall,
	output logic flush,
	output cpuPkg::bypassSelT bypassA,
	output cpuPkg::bypassSelT bypassB,
	output cpuPkg::bypassSelT bypassStore
);

	logic lastStall;

	// newest producer wins
	function automatic cpuPkg::bypassSelT pickSource(input logic [cpuPkg::regAddrWidth-1:0] src);
		cpuPkg::bypassSelT sel;
		sel = cpuPkg::bypNone;
		if (src != '0) begin
			if (memRegWrite && memRegDst == src)
				sel = cpuPkg::bypMem;
			else if (wbRegWrite && wbRegDst == src)
				sel = cpuPkg::bypWb;
		end
		return sel;
	endfunction

	always_comb begin
		bypassA = pickSource(exeRegA);
		bypassB = pickSource(exeRegB);
		// WM path, load result straight into store data
		if (memStoreReg != '0 && wbRegWrite && wbRegDst == memStoreReg)
			bypassStore = cpuPkg::bypWb;
		else
			bypassStore = cpuPkg::bypNone;
	end

	// load in execute feeding decode
	assign stall = exeValid && exeMemRead && exeRegDst != '0 &&
		(exeRegDst == decRegA || (decUsesB && exeRegDst == decRegB));
	assign flush = takeTransfer;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			lastStall <= 1'b0;
		else
			lastStall <= stall;
	end

	// the datapath must put a bubble behind every stall
	assert property (@(posedge clock) disable iff (!arstN) !(stall && lastStall));
	assert property (@(posedge clock) !arstN |-> !flush);

endmodule

/* hdl/instrDecode.sv */
`timescale 1ns/10ps

module instrDecode (
	input logic [cpuPkg::dataWidth-1:0] instr,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output logic useImm,
	output cpuPkg::wbSelT wbSel,
	output cpuPkg::aluOpT aluOp,
	output logic isBne,
	output logic isBlt,
	output logic isJump,
	output logic isJr,
	output logic [cpuPkg::regAddrWidth-1:0] readRegA,
	output logic [cpuPkg::regAddrWidth-1:0] readRegB
);

	cpuPkg::opcodeT opcode;
	logic [cpuPkg::regAddrWidth-1:0] rd, rs, rt;

	assign opcode = cpuPkg::opcodeT'(instr[31:27]);
	assign rd = instr[26:22];
	assign rs = instr[21:17];
	assign rt = instr[16:12];

	always_comb begin
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		useImm = 1'b0;
		wbSel = cpuPkg::wbAlu;
		aluOp = cpuPkg::aluAdd; // address and addi sum
		isBne = 1'b0;
		isBlt = 1'b0;
		isJump = 1'b0;
		isJr = 1'b0;
		readRegA = '0; // r0 never matches a hazard
		readRegB = '0;
		case (opcode)
			cpuPkg::opAlu: begin
				regWrite = 1'b1;
				aluOp = cpuPkg::aluOpT'(instr[6:2]);
				readRegA = rs;
				readRegB = rt;
			end
			cpuPkg::opAddi: begin
				regWrite = 1'b1;
				useImm = 1'b1;
				readRegA = rs;
			end
			cpuPkg::opLw: begin
				regWrite = 1'b1;
				memRead = 1'b1;
				useImm = 1'b1;
				wbSel = cpuPkg::wbMem;
				readRegA = rs;
			end
			cpuPkg::opSw: begin
				memWrite = 1'b1;
				useImm = 1'b1;
				readRegA = rs; // base
				readRegB = rd; // store data
			end
			cpuPkg::opBne, cpuPkg::opBlt: begin
				isBne = (opcode == cpuPkg::opBne);
				isBlt = (opcode == cpuPkg::opBlt);
				aluOp = cpuPkg::aluSub;
				readRegA = rd;
				readRegB = rs;
			end
			cpuPkg::opJ: isJump = 1'b1;
			cpuPkg::opJal: begin
				isJump = 1'b1;
				regWrite = 1'b1;
				wbSel = cpuPkg::wbLink;
			end
			cpuPkg::opJr: begin
				isJr = 1'b1;
				readRegA = rd; // jump target register
			end
			default: ; // unknown opcodes do nothing
		endcase
	end

endmodule

/* hdl/pipeDatapath.sv */
`timescale 1ns/10ps

module pipeDatapath #(
	parameter int progAddrWidth = 12
) (
	input logic clock,
	input logic arstN,
	input logic [cpuPkg::dataWidth-1:0] fetchInstr,
	output logic [progAddrWidth-1:0] pc,
	output logic [cpuPkg::dataWidth-1:0] decInstr,
	input logic decRegWrite,
	input logic decMemRead,
	input logic decMemWrite,
	input logic decUseImm,
	input cpuPkg::wbSelT decWbSel,
	input cpuPkg::aluOpT decAluOp,
	input logic decIsBne,
	input logic decIsBlt,
	input logic decIsJump,
	input logic decIsJr,
	input logic [cpuPkg::regAddrWidth-1:0] decRegA,
	input logic [cpuPkg::regAddrWidth-1:0] decRegB,
	input logic [cpuPkg::dataWidth-1:0] dataA,
	input logic [cpuPkg::dataWidth-1:0] dataB,
	input logic stall,
	input logic flush,
	input cpuPkg::bypassSelT bypassA,
	input cpuPkg::bypassSelT bypassB,
	input cpuPkg::bypassSelT bypassStore,
	input logic [cpuPkg::dataWidth-1:0] memReadData,
	output logic decUsesB,
	output logic [cpuPkg::regAddrWidth-1:0] exeRegDst,
	output logic exeMemRead,
	output logic exeValid,
	output logic [cpuPkg::regAddrWidth-1:0] exeRegA,
	output logic [cpuPkg::regAddrWidth-1:0] exeRegB,
	output logic [cpuPkg::regAddrWidth-1:0] memRegDst,
	output logic memRegWrite,
	output logic [cpuPkg::regAddrWidth-1:0] memStoreReg,
	output logic takeTransfer,
	output logic wbEnable,
	output logic [cpuPkg::regAddrWidth-1:0] wbReg,
	output logic [cpuPkg::dataWidth-1:0] wbData,
	output logic [cpuPkg::dataWidth-1:0] memAddr,
	output logic [cpuPkg::dataWidth-1:0] memWriteData,
	output logic memWrite
);

	localparam int dw = cpuPkg::dataWidth;

	logic decValid, memValid, wbValid;
	logic [progAddrWidth-1:0] pcPlusOne, nextPc, decPc1, exePc1, branchTarget, jumpTarget, exeTarget;
	logic [dw-1:0] decImm, exeImm, exeDataA, exeDataB, opA, opB, aluB, aluResult, exeResult;
	logic [cpuPkg::regAddrWidth-1:0] decRegDst, exeStoreReg;
	logic [4:0] exeShamt;
	logic exeRegWrite, exeMemWrite, exeUseImm, exeIsBne, exeIsBlt, exeIsJump, exeIsJr;
	logic notEqual, lessThan;
	cpuPkg::wbSelT exeWbSel, memWbSel, wbSrc;
	cpuPkg::aluOpT exeAluOp;
	logic memWritesReg, memIsLoad, memIsStore, wbWritesReg;
	logic [dw-1:0] memResult, memStoreData, wbResult, wbLoadData;

	////////////////////////////////////////////////////////////////////////////
	// fetch and decode
	////////////////////////////////////////////////////////////////////////////

	assign pcPlusOne = pc + progAddrWidth'(1);
	assign decImm = {{(dw-17){decInstr[16]}}, decInstr[16:0]}; // 17-bit signed immediate
	assign branchTarget = decPc1 + decImm[progAddrWidth-1:0];
	assign jumpTarget = decInstr[progAddrWidth-1:0];
	assign decRegDst = (decWbSel == cpuPkg::wbLink) ? cpuPkg::regLink : decInstr[26:22];
	assign decUsesB = !decUseImm; // rt, or rs of a branch

	////////////////////////////////////////////////////////////////////////////
	// execute
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (bypassA)
			cpuPkg::bypMem: opA = memResult; // MX
			cpuPkg::bypWb: opA = wbData; // WX
			default: opA = exeDataA;
		endcase
		case (bypassB)
			cpuPkg::bypMem: opB = memResult;
			cpuPkg::bypWb: opB = wbData;
			default: opB = exeDataB;
		endcase
	end

	assign aluB = exeUseImm ? exeImm : opB;

	aluUnit alu (
		.opA(opA),
		.opB(aluB),
		.aluOp(exeAluOp),
		.shiftAmt(exeShamt),
		.result(aluResult),
		.notEqual(notEqual),
		.lessThan(lessThan)
	);

	// jal carries its link value in place of the alu result
	assign exeResult = (exeWbSel == cpuPkg::wbLink) ? dw'(exePc1) : aluResult;
	assign takeTransfer = exeValid &&
		((exeIsBne && notEqual) || (exeIsBlt && lessThan) || exeIsJump || exeIsJr);

	always_comb begin
		if (takeTransfer)
			nextPc = exeIsJr ? opA[progAddrWidth-1:0] : exeTarget;
		else if (stall)
			nextPc = pc;
		else
			nextPc = pcPlusOne;
	end

	////////////////////////////////////////////////////////////////////////////
	// memory and writeback
	////////////////////////////////////////////////////////////////////////////

	assign memAddr = memResult;
	assign memWriteData = (bypassStore == cpuPkg::bypWb) ? wbData : memStoreData;
	assign memWrite = memValid && memIsStore;
	assign memRegWrite = memValid && memWritesReg && !memIsLoad; // load data not here yet
	assign wbEnable = wbValid && wbWritesReg;
	assign wbData = (wbSrc == cpuPkg::wbMem) ? wbLoadData : wbResult;

	// pc, fetch/decode and valid bits
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
			decInstr <= '0;
			decValid <= 1'b0;
			exeValid <= 1'b0;
			memValid <= 1'b0;
			wbValid <= 1'b0;
		end else begin
			pc <= nextPc;
			if (flush) begin
				decInstr <= '0; // decodes as add r0
				decValid <= 1'b0;
			end else if (!stall) begin
				decInstr <= fetchInstr;
				decValid <= 1'b1;
			end
			exeValid <= decValid && !stall && !flush; // bubble on stall
			memValid <= exeValid;
			wbValid <= memValid;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall)
			decPc1 <= pcPlusOne;
		exeRegWrite <= decRegWrite;
		exeMemRead <= decMemRead;
		exeMemWrite <= decMemWrite;
		exeUseImm <= decUseImm;
		exeWbSel <= decWbSel;
		exeAluOp <= decAluOp;
		exeIsBne <= decIsBne;
		exeIsBlt <= decIsBlt;
		exeIsJump <= decIsJump;
		exeIsJr <= decIsJr;
		exeRegA <= decRegA;
		exeRegB <= decRegB;
		exeRegDst <= decRegDst;
		exeStoreReg <= decInstr[26:22];
		exeDataA <= dataA;
		exeDataB <= dataB;
		exeImm <= decImm;
		exeShamt <= decInstr[11:7];
		exePc1 <= decPc1;
		exeTarget <= decIsJump ? jumpTarget : branchTarget;

		memWritesReg <= exeRegWrite;
		memIsLoad <= exeMemRead;
		memIsStore <= exeMemWrite;
		memWbSel <= exeWbSel;
		memRegDst <= exeRegDst;
		memStoreReg <= exeStoreReg;
		memResult <= exeResult;
		memStoreData <= opB; // store data after MX/WX

		wbWritesReg <= memWritesReg;
		wbSrc <= memWbSel;
		wbReg <= memRegDst;
		wbResult <= memResult;
		wbLoadData <= memReadData;
	end

endmodule

/* hdl/progMem.sv */
`timescale 1ns/10ps

module progMem #(
	parameter int progAddrWidth = 12
) (
	input logic clock,
	input logic arstN,
	input logic progWrite,
	input logic [progAddrWidth-1:0] progAddr,
	input logic [cpuPkg::dataWidth-1:0] progData,
	input logic [progAddrWidth-1:0] pc,
	output logic [cpuPkg::dataWidth-1:0] instr
);

	logic [cpuPkg::dataWidth-1:0] words [2**progAddrWidth];

	always_ff @(posedge clock) begin
		if (progWrite)
			words[progAddr] <= progData;
	end

	assign instr = words[pc]; // read during fetch

	// code is loaded only while the core sits in reset
	assert property (@(posedge clock) progWrite |-> !arstN);

endmodule

/* hdl/regFile.sv */
`timescale 1ns/10ps

module regFile (
	input logic clock,
	input logic arstN,
	input logic writeEnable,
	input logic [cpuPkg::regAddrWidth-1:0] writeReg,
	input logic [cpuPkg::dataWidth-1:0] writeData,
	input logic [cpuPkg::regAddrWidth-1:0] readRegA,
	input logic [cpuPkg::regAddrWidth-1:0] readRegB,
	output logic [cpuPkg::dataWidth-1:0] dataA,
	output logic [cpuPkg::dataWidth-1:0] dataB
);

	logic [cpuPkg::dataWidth-1:0] regs [2**cpuPkg::regAddrWidth];

	// falling edge, so decode sees this cycle's writeback
	always_ff @(negedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 2**cpuPkg::regAddrWidth; i++)
				regs[i] <= '0;
		end else if (writeEnable && writeReg != '0) begin
			regs[writeReg] <= writeData;
		end
	end

	assign dataA = regs[readRegA];
	assign dataB = regs[readRegB];

	assert property (@(posedge clock) disable iff (!arstN) (readRegA == '0) |-> (dataA == '0));

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" && verilator --binary --timing --assert --timescale 1ns/10ps \
	-f verilog.f --top-module cpuBench -o cpuSim || exit 1
simOut=$(./obj_dir/cpuSim 2>&1)
echo "$simOut"
echo "$simOut" | grep -q "All tests passed" && exit 0 || exit 1

/* verilog.f */
+incdir+bench
hdl/cpuPkg.sv
hdl/aluUnit.sv
hdl/regFile.sv
hdl/instrDecode.sv
hdl/hazardControl.sv
hdl/progMem.sv
hdl/dataMem.sv
hdl/pipeDatapath.sv
hdl/cpuTop.sv
bench/cpuBench.sv
